//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_ft2232_host_model
RTL_TOP   := ft2232_host_model
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/ft_defs.svh
`ifndef FT_DEFS_SVH
`define FT_DEFS_SVH

// ====================
// Bus and field widths
// ====================

// One FIFO byte
`define FT_DATA_W 8

// Lengths and packet counts
`define FT_LEN_W 16

// Opcode sits in the top bits of a command byte
`define FT_CMD_W 3

// DATA command flag, a two byte big-endian length follows
`define FT_LONG_LEN_BIT 4

// Length carried inside the command byte itself
`define FT_SHORT_LEN_W 4

// ====================
// Fixed argument values
// ====================

`define FT_START_ARG 5
`define FT_DATA_ARG (1 << `FT_LONG_LEN_BIT)
`define FT_ERR_NONE 0

`endif

//--- rtl/ft2232_host_model.sv
`include "ft_defs.svh"

module ft2232_host_model (
    input  logic                  fifo_clk_o,
    input  logic                  ft2232_reset_n_i,
    input  ft_pkg::ft_cfg_t       cfg_i,
    input  logic                  fifo_oe_n_i,
    input  logic                  fifo_rd_n_i,
    input  logic                  fifo_wr_n_i,
    input  logic [`FT_DATA_W-1:0] fifo_data_i,
    output logic                  fifo_rxf_n_o,
    output logic                  fifo_txe_n_o,
    output logic [`FT_DATA_W-1:0] fifo_data_o,
    output ft_pkg::ft_status_t    status_o
);
    import ft_pkg::*;

    ft_beat_t beat;
    logic     bad_cmd;
    logic     halt;
    logic     stopped_seen;

    // Receive side, FPGA reads with OE# and RD# low
    ft_host_stream i_ft_host_stream (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .cfg_i            (cfg_i),
        .rd_take_i        (~fifo_oe_n_i & ~fifo_rd_n_i),
        .stopped_seen_i   (stopped_seen),
        .halt_i           (halt),
        .fifo_rxf_n_o     (fifo_rxf_n_o),
        .fifo_data_o      (fifo_data_o)
    );

    // Transmit side, FPGA writes with OE# high and WR# low
    ft_cmd_decode i_ft_cmd_decode (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .wr_take_i        (fifo_oe_n_i & ~fifo_wr_n_i),
        .fifo_data_i      (fifo_data_i),
        .halt_i           (halt),
        .fifo_txe_n_o     (fifo_txe_n_o),
        .beat_o           (beat),
        .bad_cmd_o        (bad_cmd),
        .stopped_seen_o   (stopped_seen)
    );

    ft_test_result i_ft_test_result (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .beat_i           (beat),
        .bad_cmd_i        (bad_cmd),
        .halt_o           (halt),
        .status_o         (status_o)
    );

endmodule

//--- rtl/ft_cmd_decode.sv
`include "ft_defs.svh"

module ft_cmd_decode (
    input  logic                  fifo_clk_o,
    input  logic                  ft2232_reset_n_i,
    input  logic                  wr_take_i,
    input  logic [`FT_DATA_W-1:0] fifo_data_i,
    input  logic                  halt_i,
    output logic                  fifo_txe_n_o,
    output ft_pkg::ft_beat_t      beat_o,
    output logic                  bad_cmd_o,
    output logic                  stopped_seen_o
);
    import ft_pkg::*;

    typedef enum logic [1:0] {
        D_CMD,
        D_LONG_LEN,
        D_PAYLOAD,
        D_IDLE
    } dec_state_e;

    dec_state_e            state_q;
    ft_op_e                op_q;
    logic [`FT_LEN_W-1:0]  left_q;
    logic [`FT_LEN_W-1:0]  index_q;
    logic [`FT_DATA_W-1:0] len_hi_q;
    logic                  len_lo_q;
    logic                  take;
    ft_op_e                in_op;
    logic                  known_op;
    logic [`FT_LEN_W-1:0]  short_len;
    logic [`FT_LEN_W-1:0]  long_len;

    assign take      = wr_take_i & ~fifo_txe_n_o;
    assign in_op     = ft_op_e'(fifo_data_i[`FT_DATA_W-1 -: `FT_CMD_W]);
    assign known_op  = in_op inside {FPGA_DATA, FPGA_LOOPBACK, FPGA_STOPPED};
    assign short_len = {{(`FT_LEN_W - `FT_SHORT_LEN_W){1'b0}},
                        fifo_data_i[`FT_SHORT_LEN_W-1:0]};
    assign long_len  = {len_hi_q, fifo_data_i};

    // Command-level events, both on the accepted byte
    assign bad_cmd_o      = take && (state_q == D_CMD) && !known_op;
    assign stopped_seen_o = take && (state_q == D_CMD) && (in_op == FPGA_STOPPED);

    // Payload beat straight off the bus, same edge as the write
    always_comb begin
        beat_o.valid = take && (state_q == D_PAYLOAD);
        beat_o.op    = op_q;
        beat_o.index = index_q;
        beat_o.data  = fifo_data_i;
    end

    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state_q      <= D_CMD;
            fifo_txe_n_o <= 1'b0;
            op_q         <= FPGA_DATA;
            left_q       <= '0;
            index_q      <= '0;
            len_hi_q     <= '0;
            len_lo_q     <= 1'b0;
        end else if (halt_i) begin
            // Aborted, refuse anything further from the FPGA
            state_q      <= D_IDLE;
            fifo_txe_n_o <= 1'b1;
        end else if (take) begin
            case (state_q)
                D_CMD: begin
                    if (known_op) begin
                        op_q     <= in_op;
                        index_q  <= '0;
                        len_lo_q <= 1'b0;
                        if (in_op == FPGA_DATA && fifo_data_i[`FT_LONG_LEN_BIT]) begin
                            state_q <= D_LONG_LEN;
                        end else if (short_len != '0) begin
                            left_q  <= short_len;
                            state_q <= D_PAYLOAD;
                        end
                    end
                end
                D_LONG_LEN: begin
                    // High byte first
                    if (!len_lo_q) begin
                        len_hi_q <= fifo_data_i;
                        len_lo_q <= 1'b1;
                    end else begin
                        left_q  <= long_len;
                        state_q <= (long_len != '0) ? D_PAYLOAD : D_CMD;
                    end
                end
                D_PAYLOAD: begin
                    left_q  <= left_q - 16'd1;
                    index_q <= index_q + 16'd1;
                    if (left_q == 16'd1) begin
                        state_q <= D_CMD;
                    end
                end
                default: state_q <= D_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/ft_host_stream.sv
`include "ft_defs.svh"

module ft_host_stream (
    input  logic                  fifo_clk_o,
    input  logic                  ft2232_reset_n_i,
    input  ft_pkg::ft_cfg_t       cfg_i,
    input  logic                  rd_take_i,
    input  logic                  stopped_seen_i,
    input  logic                  halt_i,
    output logic                  fifo_rxf_n_o,
    output logic [`FT_DATA_W-1:0] fifo_data_o
);
    import ft_pkg::*;

    localparam int ARG_W = `FT_DATA_W - `FT_CMD_W;

    typedef enum logic [3:0] {
        H_START,
        H_TEST_ID,
        H_LEN_HI,
        H_LEN_LO,
        H_CNT_HI,
        H_CNT_LO,
        H_DATA_CMD,
        H_DATA_LEN_HI,
        H_DATA_LEN_LO,
        H_PAYLOAD,
        H_STOP,
        H_DONE
    } host_state_e;

    host_state_e           state_q;
    logic [`FT_LEN_W-1:0]  pkt_left_q;
    logic [`FT_LEN_W-1:0]  byte_left_q;
    logic [`FT_DATA_W-1:0] pay_data_q;
    logic                  take;
    logic                  rx_test;

    // A byte only leaves while the FIFO reports data available
    assign take    = rd_take_i & ~fifo_rxf_n_o;
    assign rx_test = (cfg_i.test_id == TEST_RECEIVE) || (cfg_i.test_id == TEST_RECEIVE_SEND);

    // ====================
    // Current byte
    // ====================
    always_comb begin
        case (state_q)
            H_START:       fifo_data_o = {HOST_START, ARG_W'(`FT_START_ARG)};
            H_TEST_ID:     fifo_data_o = cfg_i.test_id;
            H_LEN_HI:      fifo_data_o = cfg_i.payload_len[15:8];
            H_LEN_LO:      fifo_data_o = cfg_i.payload_len[7:0];
            H_CNT_HI:      fifo_data_o = cfg_i.packet_count[15:8];
            H_CNT_LO:      fifo_data_o = cfg_i.packet_count[7:0];
            H_DATA_CMD:    fifo_data_o = {HOST_DATA, ARG_W'(`FT_DATA_ARG)};
            H_DATA_LEN_HI: fifo_data_o = cfg_i.payload_len[15:8];
            H_DATA_LEN_LO: fifo_data_o = cfg_i.payload_len[7:0];
            H_PAYLOAD:     fifo_data_o = pay_data_q;
            H_STOP:        fifo_data_o = {HOST_STOP, ARG_W'(0)};
            default:       fifo_data_o = '0;
        endcase
    end

    // ====================
    // Stream sequencer
    // ====================
    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state_q      <= H_START;
            fifo_rxf_n_o <= 1'b0;
            pkt_left_q   <= '0;
            byte_left_q  <= '0;
            pay_data_q   <= '0;
        end else if (halt_i || stopped_seen_i) begin
            // The FPGA has ended the test, stop offering bytes
            state_q      <= H_DONE;
            fifo_rxf_n_o <= 1'b1;
        end else if (take) begin
            case (state_q)
                H_START:   state_q <= H_TEST_ID;
                H_TEST_ID: state_q <= H_LEN_HI;
                H_LEN_HI:  state_q <= H_LEN_LO;
                H_LEN_LO:  state_q <= H_CNT_HI;
                H_CNT_HI:  state_q <= H_CNT_LO;
                H_CNT_LO: begin
                    pkt_left_q <= cfg_i.packet_count;
                    if (rx_test) begin
                        state_q <= H_DATA_CMD;
                    end else begin
                        // Send test, the FPGA does the talking from here
                        state_q      <= H_DONE;
                        fifo_rxf_n_o <= 1'b1;
                    end
                end
                H_DATA_CMD: begin
                    byte_left_q <= cfg_i.payload_len;
                    state_q     <= H_DATA_LEN_HI;
                end
                H_DATA_LEN_HI: state_q <= H_DATA_LEN_LO;
                H_DATA_LEN_LO: state_q <= H_PAYLOAD;
                H_PAYLOAD: begin
                    // Sequence runs on across packets and wraps at 256
                    pay_data_q  <= pay_data_q + 8'd1;
                    byte_left_q <= byte_left_q - 16'd1;
                    if (byte_left_q == 16'd1) begin
                        pkt_left_q <= pkt_left_q - 16'd1;
                        if (pkt_left_q == 16'd1) begin
                            state_q <= H_STOP;
                        end else begin
                            state_q <= H_DATA_CMD;
                        end
                    end
                end
                H_STOP: begin
                    state_q      <= H_DONE;
                    fifo_rxf_n_o <= 1'b1;
                end
                default: state_q <= H_DONE;
            endcase
        end
    end

endmodule

//--- rtl/ft_pkg.sv
`include "ft_defs.svh"

package ft_pkg;

    // Host commands travel on the receive side, FPGA commands on the transmit side
    typedef enum logic [`FT_CMD_W-1:0] {
        HOST_START    = 3'd1,
        HOST_DATA     = 3'd2,
        HOST_STOP     = 3'd3,
        FPGA_DATA     = 3'd4,
        FPGA_LOOPBACK = 3'd5,
        FPGA_STOPPED  = 3'd6
    } ft_op_e;

    typedef enum logic [`FT_DATA_W-1:0] {
        TEST_SEND         = 8'd1,
        TEST_RECEIVE      = 8'd2,
        TEST_RECEIVE_SEND = 8'd3
    } ft_test_e;

    // Held stable by the testbench for a whole run
    typedef struct packed {
        ft_test_e             test_id;
        logic [`FT_LEN_W-1:0] payload_len;
        logic [`FT_LEN_W-1:0] packet_count;
    } ft_cfg_t;

    // One payload byte parsed from the FPGA stream
    typedef struct packed {
        logic                  valid;
        ft_op_e                op;
        logic [`FT_LEN_W-1:0]  index;
        logic [`FT_DATA_W-1:0] data;
    } ft_beat_t;

    typedef struct packed {
        logic                  done;
        logic                  passed;
        logic                  aborted;
        logic [`FT_DATA_W-1:0] error_code;
        logic [`FT_DATA_W-1:0] value_received;
        logic [`FT_DATA_W-1:0] value_expected;
        logic [`FT_LEN_W-1:0]  data_count;
    } ft_status_t;

endpackage

//--- rtl/ft_test_result.sv
`include "ft_defs.svh"

module ft_test_result (
    input  logic               fifo_clk_o,
    input  logic               ft2232_reset_n_i,
    input  ft_pkg::ft_beat_t   beat_i,
    input  logic               bad_cmd_i,
    output logic               halt_o,
    output ft_pkg::ft_status_t status_o
);
    import ft_pkg::*;

    // Layout of the STOPPED report
    localparam logic [`FT_LEN_W-1:0] IDX_ERR = 16'd0;
    localparam logic [`FT_LEN_W-1:0] IDX_RCV = 16'd1;
    localparam logic [`FT_LEN_W-1:0] IDX_EXP = 16'd2;

    ft_status_t            stat_q;
    logic [`FT_DATA_W-1:0] exp_q;
    logic                  live;
    logic                  data_beat;
    logic                  stop_beat;
    logic                  mismatch;
    logic                  abort_evt;

    assign live      = ~stat_q.done;
    assign data_beat = live && beat_i.valid && (beat_i.op == FPGA_DATA);
    assign stop_beat = live && beat_i.valid && (beat_i.op == FPGA_STOPPED);
    assign mismatch  = data_beat && (beat_i.data != exp_q);
    assign abort_evt = live && (mismatch || bad_cmd_i);

    // Sticky flag plus this cycle's events, so both sides stop at once
    assign halt_o   = stat_q.aborted | abort_evt;
    assign status_o = stat_q;

    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            stat_q <= '0;
            exp_q  <= '0;
        end else if (abort_evt) begin
            stat_q.aborted <= 1'b1;
            stat_q.done    <= 1'b1;
            if (mismatch) begin
                stat_q.value_received <= beat_i.data;
                stat_q.value_expected <= exp_q;
            end
        end else if (data_beat) begin
            exp_q             <= exp_q + 8'd1;
            stat_q.data_count <= stat_q.data_count + 16'd1;
        end else if (stop_beat) begin
            case (beat_i.index)
                IDX_ERR: stat_q.error_code     <= beat_i.data;
                IDX_RCV: stat_q.value_received <= beat_i.data;
                IDX_EXP: begin
                    // Report complete, error code was captured two beats earlier
                    stat_q.value_expected <= beat_i.data;
                    stat_q.done           <= 1'b1;
                    stat_q.passed         <= (stat_q.error_code == `FT_ERR_NONE);
                end
                default: ;
            endcase
        end
    end

endmodule

//--- sources.f
+incdir+include
rtl/ft_pkg.sv
rtl/ft_host_stream.sv
rtl/ft_cmd_decode.sv
rtl/ft_test_result.sv
rtl/ft2232_host_model.sv
tests/tb_clock.sv
tests/tb_ft2232_host_model.sv

//--- tests/tb_clock.sv
module tb_clock (
    input  logic reset_req_i,
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset low from time zero and again after every request, two cycles each
    initial begin
        rst_n_o <= 1'b0;
        forever begin
            repeat (2) @(posedge clk_o);
            rst_n_o <= 1'b1;
            @(posedge reset_req_i);
            rst_n_o <= 1'b0;
        end
    end

endmodule

//--- tests/tb_ft2232_host_model.sv
`include "ft_defs.svh"

module tb_ft2232_host_model;
    timeunit 1ns;
    timeprecision 1ps;
    import ft_pkg::*;

    localparam int NUM_TESTS     = 12;
    localparam int MAX_HOST      = 76;
    localparam int MAX_RESP      = 140;
    // Strobe gaps stretch each byte over a few cycles
    localparam int TEST_CYCLES   = 4 * (MAX_HOST + MAX_RESP) + 200;
    localparam int WATCHDOG_NS   = NUM_TESTS * TEST_CYCLES * 10;
    localparam int KIND_PASS     = 0;
    localparam int KIND_REPORT   = 1;
    localparam int KIND_MISMATCH = 2;
    localparam int KIND_UNKNOWN  = 3;

    logic                  fifo_clk;
    logic                  reset_n;
    logic                  reset_req;
    ft_cfg_t               cfg;
    logic                  oe_n;
    logic                  rd_n;
    logic                  wr_n;
    logic [`FT_DATA_W-1:0] data_to_dut;
    logic                  rxf_n;
    logic                  txe_n;
    logic [`FT_DATA_W-1:0] data_from_dut;
    ft_status_t            status;

    int         seed = 36500;
    int         errors;
    int         test_errors;
    int         failed_tests;
    logic [7:0] host_q[$];
    logic [7:0] resp_q[$];

    // Reference model of the verdict for the current test
    logic       exp_passed;
    logic       exp_aborted;
    logic [7:0] exp_err;
    logic [7:0] exp_rcv;
    logic [7:0] exp_exp;
    logic [7:0] next_data;
    int         exp_count;

    tb_clock i_tb_clock (
        .reset_req_i (reset_req),
        .clk_o       (fifo_clk),
        .rst_n_o     (reset_n)
    );

    ft2232_host_model i_ft2232_host_model (
        .fifo_clk_o       (fifo_clk),
        .ft2232_reset_n_i (reset_n),
        .cfg_i            (cfg),
        .fifo_oe_n_i      (oe_n),
        .fifo_rd_n_i      (rd_n),
        .fifo_wr_n_i      (wr_n),
        .fifo_data_i      (data_to_dut),
        .fifo_rxf_n_o     (rxf_n),
        .fifo_txe_n_o     (txe_n),
        .fifo_data_o      (data_from_dut),
        .status_o         (status)
    );

    // ====================
    // Helpers
    // ====================
    function automatic int pick(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    // Opcode in the top three bits with the argument below
    function automatic logic [7:0] cmd_byte(input logic [2:0] op, input logic [4:0] arg);
        return {op, arg};
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            KIND_PASS:     return "accepted data";
            KIND_REPORT:   return "failure report";
            KIND_MISMATCH: return "sequence mismatch";
            default:       return "unknown command";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
        assert (got == want) else begin
            $display("FAILED %s: got %0h, expected %0h", name, got, want);
            test_errors++;
        end
    endtask

    task automatic require(input bit ok, input string what);
        assert (ok) else begin
            $display("Check failed: %s", what);
            test_errors++;
        end
    endtask

    // ====================
    // Expected streams
    // ====================
    task automatic build_host_stream(input ft_cfg_t c);
        int         p;
        int         b;
        logic [7:0] pay;
        host_q.delete();
        host_q.push_back(cmd_byte(HOST_START, 5'(`FT_START_ARG)));
        host_q.push_back(c.test_id);
        host_q.push_back(c.payload_len[15:8]);
        host_q.push_back(c.payload_len[7:0]);
        host_q.push_back(c.packet_count[15:8]);
        host_q.push_back(c.packet_count[7:0]);
        if (c.test_id != TEST_SEND) begin
            pay = 8'h00;
            for (p = 0; p < int'(c.packet_count); p++) begin
                host_q.push_back(cmd_byte(HOST_DATA, 5'(`FT_DATA_ARG)));
                host_q.push_back(c.payload_len[15:8]);
                host_q.push_back(c.payload_len[7:0]);
                for (b = 0; b < int'(c.payload_len); b++) begin
                    host_q.push_back(pay);
                    pay = pay + 8'd1;
                end
            end
            host_q.push_back(cmd_byte(HOST_STOP, 5'd0));
        end
    endtask

    // FPGA DATA packet carrying the next bytes of the sequence
    task automatic push_data(input int len, input bit long_len);
        int i;
        if (long_len) begin
            resp_q.push_back(cmd_byte(FPGA_DATA, 5'(`FT_DATA_ARG)));
            resp_q.push_back(8'(len >> 8));
            resp_q.push_back(8'(len));
        end else begin
            resp_q.push_back(cmd_byte(FPGA_DATA, 5'(len)));
        end
        for (i = 0; i < len; i++) begin
            resp_q.push_back(next_data);
            next_data = next_data + 8'd1;
        end
        exp_count = exp_count + len;
    endtask

    task automatic build_response(input int kind);
        int seg;
        int nseg;
        int len;
        int i;
        int bad_at;
        resp_q.delete();
        next_data   = 8'h00;
        exp_count   = 0;
        exp_passed  = (kind == KIND_PASS);
        exp_aborted = (kind == KIND_MISMATCH) || (kind == KIND_UNKNOWN);
        exp_err     = 8'(`FT_ERR_NONE);
        nseg        = pick(1, 3);
        for (seg = 0; seg < nseg; seg++) begin
            case (pick(0, 2))
                0: push_data(pick(1, 15), 1'b0);
                1: push_data(pick(16, 40), 1'b1);
                default: begin
                    // Loopback bytes are only counted by the model
                    len = pick(0, 15);
                    resp_q.push_back(cmd_byte(FPGA_LOOPBACK, 5'(len)));
                    for (i = 0; i < len; i++) begin
                        resp_q.push_back(8'(pick(0, 255)));
                    end
                end
            endcase
        end
        case (kind)
            KIND_MISMATCH: begin
                len    = pick(2, 8);
                bad_at = pick(0, len - 1);
                resp_q.push_back(cmd_byte(FPGA_DATA, 5'(len)));
                for (i = 0; i < bad_at; i++) begin
                    resp_q.push_back(next_data);
                    next_data = next_data + 8'd1;
                end
                resp_q.push_back(next_data ^ 8'(pick(1, 255)));
                for (i = bad_at + 1; i < len; i++) begin
                    resp_q.push_back(8'(pick(0, 255)));
                end
                exp_count = exp_count + bad_at;
            end
            KIND_UNKNOWN: begin
                resp_q.push_back(cmd_byte((pick(0, 1) == 1) ? 3'd7 : 3'd0, 5'(pick(0, 31))));
            end
            default: begin
                if (kind == KIND_REPORT) begin
                    exp_err = 8'(pick(1, 255));
                end
                exp_rcv = 8'(pick(0, 255));
                exp_exp = 8'(pick(0, 255));
                resp_q.push_back(cmd_byte(FPGA_STOPPED, 5'd3));
                resp_q.push_back(exp_err);
                resp_q.push_back(exp_rcv);
                resp_q.push_back(exp_exp);
            end
        endcase
    endtask

    // ====================
    // Bus activity
    // ====================
    task automatic start_test(input ft_cfg_t c);
        wait (reset_n);
        @(posedge fifo_clk);
        reset_req <= 1'b1;
        cfg       <= c;
        oe_n      <= 1'b1;
        rd_n      <= 1'b1;
        wr_n      <= 1'b1;
        @(posedge fifo_clk);
        reset_req <= 1'b0;
        wait (reset_n);
    endtask

    // Reads limit bytes, or the whole stream up to rxf_n when limit covers it
    task automatic read_host_stream(input int limit);
        int idx;
        int want;
        bit running;
        bit whole;
        idx     = 0;
        running = 1'b1;
        whole   = (limit >= host_q.size());
        want    = whole ? host_q.size() : limit;
        while (running) begin
            @(posedge fifo_clk);
            oe_n <= (pick(0, 3) == 0);
            rd_n <= (pick(0, 2) == 0);
            wr_n <= 1'b1;
            @(negedge fifo_clk);
            if (rxf_n) begin
                running = 1'b0;
            end else if (!oe_n && !rd_n) begin
                // This byte leaves at the coming edge
                if (idx < host_q.size()) begin
                    compare_value("fifo_data_o", 16'(data_from_dut), 16'(host_q[idx]));
                end
                idx++;
                running = whole ? (idx <= want) : (idx < want);
            end
        end
        require(idx == want,
                $sformatf("host stream gave %0d bytes where %0d were due", idx, want));
    endtask

    task automatic write_responses();
        bit running;
        bit refused;
        running = 1'b1;
        refused = 1'b0;
        while (running) begin
            @(posedge fifo_clk);
            rd_n <= 1'b1;
            if (resp_q.size() == 0 || refused) begin
                oe_n    <= 1'b1;
                wr_n    <= 1'b1;
                running = 1'b0;
            end else begin
                oe_n        <= (pick(0, 7) != 0);
                wr_n        <= (pick(0, 3) == 0);
                data_to_dut <= resp_q[0];
                @(negedge fifo_clk);
                if (txe_n) begin
                    refused = 1'b1;
                end else if (oe_n && !wr_n) begin
                    void'(resp_q.pop_front());
                end
            end
        end
    endtask

    task automatic verify_verdict(input int kind);
        int n;
        @(negedge fifo_clk);
        n = 0;
        while (!status.done && n < 20) begin
            @(negedge fifo_clk);
            n++;
        end
        require(status.done, "status done never rose after the responses");
        compare_value("status_o.passed", 16'(status.passed), 16'(exp_passed));
        compare_value("status_o.aborted", 16'(status.aborted), 16'(exp_aborted));
        compare_value("status_o.data_count", status.data_count, 16'(exp_count));
        if (!exp_aborted) begin
            compare_value("status_o.error_code", 16'(status.error_code), 16'(exp_err));
            compare_value("status_o.value_received", 16'(status.value_received), 16'(exp_rcv));
            compare_value("status_o.value_expected", 16'(status.value_expected), 16'(exp_exp));
        end
        // Transmit side closes only on an abort, receive side closes in every case
        compare_value("fifo_txe_n_o", 16'(txe_n), 16'(exp_aborted));
        compare_value("fifo_rxf_n_o", 16'(rxf_n), 16'd1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        ft_cfg_t c;
        int      t;
        int      kind;
        int      limit;
        reset_req    <= 1'b0;
        cfg          <= '0;
        oe_n         <= 1'b1;
        rd_n         <= 1'b1;
        wr_n         <= 1'b1;
        data_to_dut  <= '0;
        errors       = 0;
        failed_tests = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            kind           = t % 4;
            // Every test id meets every response kind
            c.test_id      = ft_test_e'(8'((t / 4) % 3 + 1));
            c.payload_len  = 16'(pick(1, 20));
            c.packet_count = 16'(pick(1, 3));
            test_errors    = 0;
            build_host_stream(c);
            build_response(kind);
            // Other kinds stop reading early so the FPGA side has to close the stream
            limit = (kind == KIND_PASS) ? host_q.size() : pick(1, host_q.size() - 1);
            start_test(c);
            read_host_stream(limit);
            write_responses();
            verify_verdict(kind);
            errors = errors + test_errors;
            if (test_errors != 0) begin
                failed_tests++;
            end
            $display("Test %0d %s, id %0d, %0d x %0d bytes: %0d errors", t, kind_name(kind),
                     c.test_id, c.packet_count, c.payload_len, test_errors);
        end
        $display("Summary: %0d tests, %0d failed, %0d failed checks",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
